//--- Makefile
# Verilator build and run for the TURF register testbench

VERILATOR  ?= verilator
TOP        ?= tb_turf_regs
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= Regression passed

SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS := tb_turf_checks.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- baud_tick_gen.sv
module baud_tick_gen #(
    parameter int unsigned TICK_ADD  = 1,
    parameter int unsigned TICK_BITS = 8
) (
    input  logic ps_clk,
    input  logic rst_n_i,
    output logic tick_o
);

    logic [TICK_BITS-1:0] acc_q;
    logic [TICK_BITS:0]   sum;

    // Carry out of the low bits is the tick
    assign sum = {1'b0, acc_q} + (TICK_BITS + 1)'(TICK_ADD);

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            acc_q  <= '0;
            tick_o <= 1'b0;
        end else begin
            acc_q  <= sum[TICK_BITS-1:0];
            tick_o <= sum[TICK_BITS];
        end
    end

endmodule

//--- crate_bridge.sv
module crate_bridge (
    input  logic                                             ps_clk,
    input  logic                                             rst_n_i,
    input  turf_pkg::wb_req_t                                wb_req_i,
    output turf_pkg::wb_rsp_t                                wb_rsp_o,
    input  turf_pkg::bridge_kind_t [turf_pkg::NUM_LINKS-1:0] bridge_type_i,
    input  turf_pkg::link_mask_t                             aurora_up_i,
    output turf_pkg::crate_cmd_t                             cmd_o,
    output logic                                             cmd_valid_o,
    input  logic                                             cmd_ready_i,
    input  turf_pkg::crate_resp_t                            resp_i,
    input  logic                                             resp_valid_i,
    output logic                                             resp_ready_o,
    output turf_pkg::link_mask_t                             timeout_o,
    output turf_pkg::link_mask_t                             invalid_o
);
    import turf_pkg::*;

    bridge_state_t state_q;
    bridge_timer_t timer_q;
    link_mask_t    timeout_q;
    link_mask_t    invalid_q;

    // Latched access
    link_id_t    link_q;
    crate_addr_t remote_q;
    logic        we_q;
    wb_data_t    wdata_q;
    wb_data_t    rdata_q;

    link_id_t     req_link;
    crate_addr_t  req_remote;
    bridge_kind_t req_kind;
    logic         start;
    logic         kind_none;
    logic         kind_up;
    logic         active;
    logic         cmd_xfer;
    logic         resp_hit;
    logic         timeout_hit;
    wb_data_t     addr_word;

    assign req_link   = wb_req_i.adr[CRATE_ADDR_BITS +: LINK_ID_BITS];
    assign req_remote = wb_req_i.adr[CRATE_ADDR_BITS-1:0];
    assign req_kind   = bridge_type_i[req_link];
    assign start      = (state_q == IDLE) & wb_req_i.cyc & wb_req_i.stb;

    // Link validity from type and link status
    assign kind_none = (req_kind == BRIDGE_KIND_NONE);
    assign kind_up   = (req_kind == BRIDGE_KIND_AURORA) & aurora_up_i[req_link];

    assign active   = (state_q == SEND_ADDR) | (state_q == SEND_DATA) | (state_q == WAIT_RESP);
    assign cmd_xfer = cmd_valid_o & cmd_ready_i;

    // Other links' responses are dropped
    assign resp_hit    = (state_q == WAIT_RESP) & resp_valid_i & (resp_i.link == link_q);
    assign timeout_hit = active & (timer_q == BRIDGE_TIMER_LAST) & ~resp_hit;

    ////////////////////////////////////////////////////////////
    // Access FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            timer_q   <= '0;
            timeout_q <= '0;
            invalid_q <= '0;
        end else begin
            timer_q   <= active ? timer_q + 1'b1 : '0;
            timeout_q <= timeout_hit ? link_mask_t'(1) << link_q : '0;
            invalid_q <= (start & ~kind_none & ~kind_up) ? link_mask_t'(1) << req_link : '0;
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= kind_up ? SEND_ADDR : DONE;
                    end
                end
                SEND_ADDR: begin
                    if (timeout_hit) begin
                        state_q <= DONE;
                    end else if (cmd_xfer) begin
                        state_q <= we_q ? SEND_DATA : WAIT_RESP;
                    end
                end
                SEND_DATA: begin
                    if (timeout_hit) begin
                        state_q <= DONE;
                    end else if (cmd_xfer) begin
                        state_q <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (resp_hit || timeout_hit) begin
                        state_q <= DONE;
                    end
                end
                DONE: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge ps_clk) begin
        if (start) begin
            link_q   <= req_link;
            remote_q <= req_remote;
            we_q     <= wb_req_i.we;
            wdata_q  <= wb_req_i.dat;
            rdata_q  <= kind_none ? BRIDGE_NONE_DATA : BRIDGE_INVALID_DATA;
        end else if (resp_hit) begin
            rdata_q <= resp_i.data;
        end else if (timeout_hit) begin
            rdata_q <= BRIDGE_TIMEOUT_DATA;
        end
    end

    ////////////////////////////////////////////////////////////
    // Command stream
    ////////////////////////////////////////////////////////////

    always_comb begin
        addr_word                = wb_data_t'(remote_q);
        addr_word[CMD_WRITE_BIT] = we_q;
        cmd_o.data = (state_q == SEND_DATA) ? wdata_q : addr_word;
        cmd_o.dest = link_q;
        // Reads end on the address word
        cmd_o.last = (state_q == SEND_DATA) | ~we_q;
    end

    assign cmd_valid_o  = (state_q == SEND_ADDR) | (state_q == SEND_DATA);
    assign resp_ready_o = 1'b1;

    assign wb_rsp_o  = '{ack: (state_q == DONE), dat: rdata_q};
    assign timeout_o = timeout_q;
    assign invalid_o = invalid_q;

endmodule

//--- filelist.f
+incdir+.
turf_pkg.sv
baud_tick_gen.sv
turf_intercon.sv
turf_id_ctrl.sv
crate_bridge.sv
turf_regs_top.sv
tb_turf_regs.sv

//--- tb_turf_checks.svh
`ifndef TB_TURF_CHECKS_SVH
`define TB_TURF_CHECKS_SVH

int n_checks = 0;
int n_errors = 0;
int test_errors = 0;

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic check_data(input wb_data_t got, input wb_data_t exp, input string msg);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("FAILED at %0t: %s, expected %h, got %h", $time, msg, exp, got);
    end
endtask

task automatic check_status(input link_mask_t got_inv, input link_mask_t got_to,
                            input link_mask_t exp_inv, input link_mask_t exp_to,
                            input string msg);
    n_checks++;
    if (got_inv !== exp_inv || got_to !== exp_to) begin
        n_errors++;
        $display("FAILED at %0t: %s, expected invalid %b timeout %b, got invalid %b timeout %b",
                 $time, msg, exp_inv, exp_to, got_inv, got_to);
    end
endtask

task automatic check_cmd(input crate_cmd_t got, input crate_cmd_t exp, input string msg);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("FAILED at %0t: %s, expected %h/%0d/%b, got %h/%0d/%b", $time, msg,
                 exp.data, exp.dest, exp.last, got.data, got.dest, got.last);
    end
endtask

// Single handshake flag
task automatic check_flag(input logic got, input logic exp, input string msg);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("FAILED at %0t: %s, expected %b, got %b", $time, msg, exp, got);
    end
endtask

// Count within a tolerance
task automatic check_count(input int got, input int exp, input int tol, input string msg);
    n_checks++;
    if (got > exp + tol || got < exp - tol) begin
        n_errors++;
        $display("FAILED at %0t: %s, expected %0d (+/-%0d), got %0d", $time, msg, exp, tol, got);
    end
endtask

task automatic start_test();
    test_errors = n_errors;
endtask

task automatic end_test(input int num, input string name);
    $display("Test %0d %s: %0d errors", num, name, n_errors - test_errors);
endtask

////////////////////////////////////////////////////////////
// Register bus access
////////////////////////////////////////////////////////////

task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                          output wb_data_t rdat, output int latency);
    logic got_ack;
    got_ack = 1'b0;
    latency = 0;
    rdat    = '0;
    @(posedge ps_clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    while (!got_ack && latency < WAIT_LIMIT) begin
        @(posedge ps_clk);
        latency++;
        @(negedge ps_clk);
        if (wb_rsp.ack) begin
            got_ack = 1'b1;
            rdat    = wb_rsp.dat;
        end
    end
    if (!got_ack) begin
        abort_on_timeout($sformatf("register ack at address %h", adr));
    end else begin
        @(posedge ps_clk);
        wb_req <= '0;
    end
endtask

`endif

//--- tb_turf_regs.sv
module tb_turf_regs;
    import turf_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 1000;
    localparam int TICK_WINDOW  = 10240;

    typedef enum logic [1:0] {
        RESP_NORMAL,
        RESP_SILENT,
        RESP_WRONG_FIRST
    } resp_mode_t;

    logic        ps_clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    link_mask_t  aurora_up;
    crate_cmd_t  cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    crate_resp_t resp;
    logic        resp_valid;
    logic        resp_ready;
    logic        hsk_tick;
    logic        gps_tick;

    resp_mode_t  resp_mode;
    crate_cmd_t  cmd_log[$];

    task automatic abort_on_timeout(input string what);
        $display("Timeout after %0d cycles waiting for %s at %0t", WAIT_LIMIT, what, $time);
        $display("Regression failed");
        $finish;
    endtask

`include "tb_turf_checks.svh"

    turf_regs_top UUT (
        .ps_clk       (ps_clk),
        .rst_n_i      (rst_n),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .aurora_up_i  (aurora_up),
        .cmd_o        (cmd),
        .cmd_valid_o  (cmd_valid),
        .cmd_ready_i  (cmd_ready),
        .resp_i       (resp),
        .resp_valid_i (resp_valid),
        .resp_ready_o (resp_ready),
        .hsk_tick_o   (hsk_tick),
        .gps_tick_o   (gps_tick)
    );

    initial begin
        ps_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ps_clk = ~ps_clk;
    end

    function automatic wb_addr_t crate_address(input link_id_t link, input crate_addr_t remote);
        return {1'b1, link, remote};
    endfunction

    // Address word as the link sees it
    function automatic wb_data_t address_word(input logic we, input crate_addr_t remote);
        wb_data_t word;
        word                        = '0;
        word[CRATE_ADDR_BITS-1:0]   = remote;
        word[CMD_WRITE_BIT]         = we;
        return word;
    endfunction

    function automatic wb_data_t link_pattern(input link_id_t link, input wb_data_t addr_word);
        return (addr_word * 32'h9E37_79B1) ^ {link, 30'h1555_5555};
    endfunction

    ////////////////////////////////////////////////////////////
    // Link responder model
    ////////////////////////////////////////////////////////////

    initial begin
        cmd_ready = 1'b0;
        forever begin
            @(posedge ps_clk);
            cmd_ready <= ($urandom_range(3) != 0);
        end
    end

    initial begin : link_responder
        crate_cmd_t seen;
        wb_data_t   addr_word;
        logic       want_addr;
        resp       = '0;
        resp_valid = 1'b0;
        want_addr  = 1'b1;
        addr_word  = '0;
        forever begin
            @(negedge ps_clk);
            if (rst_n && cmd_valid && cmd_ready) begin
                seen = cmd;
                cmd_log.push_back(seen);
                if (want_addr) begin
                    addr_word = seen.data;
                end
                want_addr = seen.last;
                if (seen.last && resp_mode != RESP_SILENT) begin
                    repeat ($urandom_range(6, 1)) @(posedge ps_clk);
                    // Stray word for another link goes first
                    if (resp_mode == RESP_WRONG_FIRST) begin
                        resp       <= '{data: ~link_pattern(seen.dest, addr_word),
                                        link: link_id_t'(seen.dest + 2'd1)};
                        resp_valid <= 1'b1;
                        @(posedge ps_clk);
                    end
                    resp       <= '{data: link_pattern(seen.dest, addr_word), link: seen.dest};
                    resp_valid <= 1'b1;
                    @(negedge ps_clk);
                    check_flag(resp_ready, 1'b1, "resp_ready with response word");
                    @(posedge ps_clk);
                    resp_valid <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin : main
        wb_data_t     rdat;
        wb_data_t     wdat;
        wb_data_t     exp;
        wb_addr_t     adr;
        link_id_t     link;
        crate_addr_t  remote;
        crate_cmd_t   exp_cmd;
        bridge_kind_t kind;
        logic         we;
        logic [7:0]   types;
        logic [7:0]   clr;
        link_mask_t   up_mask;
        link_mask_t   exp_inv;
        int           lat;
        int           hsk_count;
        int           gps_count;

        void'($urandom(17918));
        rst_n     = 1'b0;
        wb_req    = '0;
        aurora_up = '0;
        resp_mode = RESP_NORMAL;
        repeat (RESET_CYCLES) @(posedge ps_clk);
        rst_n <= 1'b1;

        start_test();
        exp = "TURF";
        bus_access(1'b0, wb_addr_t'(IDCTL_ID_OFFSET), '0, rdat, lat);
        check_data(rdat, exp, "ID word");
        check_count(lat, 2, 0, "ID ack latency");
        exp = {REV_B, FIRMWARE_DATE[14:0], VER_MAJOR, VER_MINOR, VER_REV};
        bus_access(1'b0, wb_addr_t'(IDCTL_DATEVER_OFFSET), '0, rdat, lat);
        check_data(rdat, exp, "DATEVERSION word");
        check_count(lat, 2, 0, "DATEVERSION ack latency");
        end_test(1, "identification");

        start_test();
        repeat (8) begin
            adr                  = wb_addr_t'($urandom);
            adr[CRATE_SPACE_BIT] = 1'b0;
            if (adr[CRATE_SPACE_BIT-1:IDCTL_ADDR_BITS] == '0) begin
                adr[IDCTL_ADDR_BITS] = 1'b1;
            end
            bus_access(1'($urandom_range(1)), adr, $urandom, rdat, lat);
            check_data(rdat, UNMAPPED_DATA, "unmapped access");
            check_count(lat, 2, 0, "unmapped ack latency");
        end
        wdat = $urandom;
        bus_access(1'b1, wb_addr_t'(IDCTL_BTYPE_OFFSET), wdat, rdat, lat);
        bus_access(1'b0, wb_addr_t'(IDCTL_BTYPE_OFFSET), '0, rdat, lat);
        check_data(rdat, {24'h0, wdat[7:0]}, "bridge type readback");
        end_test(2, "unmapped");

        start_test();
        repeat (4) begin
            types   = 8'($urandom);
            up_mask = link_mask_t'($urandom);
            @(posedge ps_clk);
            aurora_up <= up_mask;
            bus_access(1'b1, wb_addr_t'(IDCTL_BTYPE_OFFSET), wb_data_t'(types), rdat, lat);
            bus_access(1'b1, wb_addr_t'(IDCTL_BSTAT_OFFSET), 32'hFF, rdat, lat);
            exp_inv = '0;
            for (int i = 0; i < NUM_LINKS; i++) begin
                kind   = types[2*i +: 2];
                remote = crate_addr_t'($urandom);
                bus_access(1'b0, crate_address(link_id_t'(i), remote), '0, rdat, lat);
                if (kind == BRIDGE_KIND_NONE) begin
                    exp = BRIDGE_NONE_DATA;
                end else if (kind == BRIDGE_KIND_AURORA && up_mask[i]) begin
                    exp = link_pattern(link_id_t'(i), address_word(1'b0, remote));
                end else begin
                    exp        = BRIDGE_INVALID_DATA;
                    exp_inv[i] = 1'b1;
                end
                check_data(rdat, exp, $sformatf("crate read, link %0d type %0d", i, kind));
            end
            bus_access(1'b0, wb_addr_t'(IDCTL_BSTAT_OFFSET), '0, rdat, lat);
            check_status(rdat[3:0], rdat[7:4], exp_inv, '0, "status after type reads");
            clr = 8'($urandom);
            bus_access(1'b1, wb_addr_t'(IDCTL_BSTAT_OFFSET), wb_data_t'(clr), rdat, lat);
            exp_inv = exp_inv & ~clr[3:0];
            bus_access(1'b0, wb_addr_t'(IDCTL_BSTAT_OFFSET), '0, rdat, lat);
            check_status(rdat[3:0], rdat[7:4], exp_inv, '0, "status after clear");
        end
        end_test(3, "bridge types");

        start_test();
        @(posedge ps_clk);
        aurora_up <= 4'hF;
        bus_access(1'b1, wb_addr_t'(IDCTL_BTYPE_OFFSET), 32'h55, rdat, lat);
        repeat (12) begin
            link      = link_id_t'($urandom);
            remote    = crate_addr_t'($urandom);
            we        = 1'($urandom_range(1));
            wdat      = $urandom;
            resp_mode = ($urandom_range(1) != 0) ? RESP_WRONG_FIRST : RESP_NORMAL;
            cmd_log.delete();
            bus_access(we, crate_address(link, remote), wdat, rdat, lat);
            check_data(rdat, link_pattern(link, address_word(we, remote)), "forwarded data");
            check_count(cmd_log.size(), we ? 2 : 1, 0, "command word count");
            exp_cmd = '{data: address_word(we, remote), dest: link, last: ~we};
            if (cmd_log.size() > 0) begin
                check_cmd(cmd_log[0], exp_cmd, "address word");
            end
            exp_cmd = '{data: wdat, dest: link, last: 1'b1};
            if (we && cmd_log.size() > 1) begin
                check_cmd(cmd_log[1], exp_cmd, "data word");
            end
        end
        end_test(4, "forwarded accesses");

        start_test();
        resp_mode = RESP_SILENT;
        for (int i = 0; i < 2; i++) begin
            link = link_id_t'($urandom);
            bus_access(1'b1, wb_addr_t'(IDCTL_BSTAT_OFFSET), 32'hFF, rdat, lat);
            bus_access(1'(i), crate_address(link, crate_addr_t'($urandom)), $urandom, rdat, lat);
            check_data(rdat, BRIDGE_TIMEOUT_DATA, "silent link");
            bus_access(1'b0, wb_addr_t'(IDCTL_BSTAT_OFFSET), '0, rdat, lat);
            check_status(rdat[3:0], rdat[7:4], '0, link_mask_t'(1) << link, "timeout status");
        end
        resp_mode = RESP_NORMAL;
        end_test(5, "timeout");

        start_test();
        hsk_count = 0;
        gps_count = 0;
        repeat (TICK_WINDOW) begin
            @(negedge ps_clk);
            hsk_count += int'(hsk_tick);
            gps_count += int'(gps_tick);
        end
        check_count(hsk_count, (TICK_WINDOW * HSK_TICK_ADD) >> HSK_TICK_BITS, 1, "hsk ticks");
        check_count(gps_count, (TICK_WINDOW * GPS_TICK_ADD) >> GPS_TICK_BITS, 1, "gps ticks");
        end_test(6, "tick rates");

        $display("Checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- turf_id_ctrl.sv
module turf_id_ctrl (
    input  logic                                             ps_clk,
    input  logic                                             rst_n_i,
    input  turf_pkg::wb_req_t                                wb_req_i,
    output turf_pkg::wb_rsp_t                                wb_rsp_o,
    output turf_pkg::bridge_kind_t [turf_pkg::NUM_LINKS-1:0] bridge_type_o,
    input  turf_pkg::link_mask_t                             timeout_i,
    input  turf_pkg::link_mask_t                             invalid_i
);
    import turf_pkg::*;

    logic                         ack_q;
    wb_data_t                     dat_q;
    bridge_kind_t [NUM_LINKS-1:0] bridge_type_q;
    link_mask_t                   invalid_q;
    link_mask_t                   timeout_q;

    idctl_offset_t offset;
    logic          access;
    logic          wr_type;
    logic          wr_status;
    link_mask_t    clr_invalid;
    link_mask_t    clr_timeout;
    wb_data_t      rd_data;

    // Strobe stays up through the ack cycle
    assign access    = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign offset    = wb_req_i.adr[IDCTL_ADDR_BITS-1:0];
    assign wr_type   = access & wb_req_i.we & (offset == IDCTL_BTYPE_OFFSET);
    assign wr_status = access & wb_req_i.we & (offset == IDCTL_BSTAT_OFFSET);

    // Write one to clear
    assign clr_invalid = wr_status ? wb_req_i.dat[NUM_LINKS-1:0] : '0;
    assign clr_timeout = wr_status ? wb_req_i.dat[2*NUM_LINKS-1:NUM_LINKS] : '0;

    always_comb begin
        case (offset)
            IDCTL_ID_OFFSET:      rd_data = IDENT_WORD;
            IDCTL_DATEVER_OFFSET: rd_data = DATEVERSION;
            IDCTL_BTYPE_OFFSET:   rd_data = wb_data_t'(bridge_type_q);
            IDCTL_BSTAT_OFFSET:   rd_data = wb_data_t'({timeout_q, invalid_q});
            default:              rd_data = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control and status registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            ack_q         <= 1'b0;
            bridge_type_q <= '0;
            invalid_q     <= '0;
            timeout_q     <= '0;
        end else begin
            ack_q <= access;
            if (wr_type) begin
                bridge_type_q <= wb_req_i.dat[NUM_LINKS*BRIDGE_KIND_BITS-1:0];
            end
            // New event beats the clear
            invalid_q <= (invalid_q & ~clr_invalid) | invalid_i;
            timeout_q <= (timeout_q & ~clr_timeout) | timeout_i;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (access) begin
            dat_q <= rd_data;
        end
    end

    assign wb_rsp_o      = '{ack: ack_q, dat: dat_q};
    assign bridge_type_o = bridge_type_q;

endmodule

//--- turf_intercon.sv
module turf_intercon (
    input  logic              ps_clk,
    input  logic              rst_n_i,
    input  turf_pkg::wb_req_t wb_req_i,
    output turf_pkg::wb_rsp_t wb_rsp_o,
    output turf_pkg::wb_req_t idctl_req_o,
    input  turf_pkg::wb_rsp_t idctl_rsp_i,
    output turf_pkg::wb_req_t crate_req_o,
    input  turf_pkg::wb_rsp_t crate_rsp_i
);
    import turf_pkg::*;

    wb_req_t req_q;
    logic    busy_q;
    logic    unm_ack_q;
    logic    accept;
    logic    sel_crate;
    logic    sel_idctl;
    logic    sel_unmapped;

    // One access in flight, new one only when idle
    assign accept = wb_req_i.cyc & wb_req_i.stb & ~busy_q;

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (wb_rsp_o.ack) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (accept) begin
            req_q <= wb_req_i;
        end
    end

    // Address decode on the registered request
    assign sel_crate    = req_q.adr[CRATE_SPACE_BIT];
    assign sel_idctl    = (req_q.adr[WB_ADDR_BITS-1:IDCTL_ADDR_BITS] == '0);
    assign sel_unmapped = ~sel_crate & ~sel_idctl;

    always_comb begin
        idctl_req_o     = req_q;
        idctl_req_o.cyc = busy_q & sel_idctl;
        idctl_req_o.stb = busy_q & sel_idctl;
        crate_req_o     = req_q;
        crate_req_o.cyc = busy_q & sel_crate;
        crate_req_o.stb = busy_q & sel_crate;
    end

    // Unmapped space answers here
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            unm_ack_q <= 1'b0;
        end else begin
            unm_ack_q <= busy_q & sel_unmapped & ~unm_ack_q;
        end
    end

    always_comb begin
        wb_rsp_o.ack = idctl_rsp_i.ack | crate_rsp_i.ack | unm_ack_q;
        wb_rsp_o.dat = ({WB_DATA_BITS{idctl_rsp_i.ack}} & idctl_rsp_i.dat)
                     | ({WB_DATA_BITS{crate_rsp_i.ack}} & crate_rsp_i.dat)
                     | ({WB_DATA_BITS{unm_ack_q}} & UNMAPPED_DATA);
    end

endmodule

//--- turf_pkg.sv
package turf_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int WB_ADDR_BITS     = 28;
    localparam int WB_DATA_BITS     = 32;
    localparam int CRATE_ADDR_BITS  = 25;
    localparam int LINK_ID_BITS     = 2;
    localparam int NUM_LINKS        = 4;
    localparam int BRIDGE_KIND_BITS = 2;

    typedef logic [WB_ADDR_BITS-1:0]     wb_addr_t;
    typedef logic [WB_DATA_BITS-1:0]     wb_data_t;
    typedef logic [CRATE_ADDR_BITS-1:0]  crate_addr_t;
    typedef logic [LINK_ID_BITS-1:0]     link_id_t;
    typedef logic [NUM_LINKS-1:0]        link_mask_t;
    typedef logic [BRIDGE_KIND_BITS-1:0] bridge_kind_t;

    // Codes 2 and 3 are not implemented yet
    localparam bridge_kind_t BRIDGE_KIND_NONE   = 2'd0;
    localparam bridge_kind_t BRIDGE_KIND_AURORA = 2'd1;

    ////////////////////////////////////////////////////////////
    // Identity and version
    ////////////////////////////////////////////////////////////

    // ASCII "TURF"
    localparam wb_data_t    IDENT_WORD       = 32'h5455_5246;
    localparam logic [3:0]  VER_MAJOR        = 4'd0;
    localparam logic [3:0]  VER_MINOR        = 4'd4;
    localparam logic [7:0]  VER_REV          = 8'd0;
    localparam logic [15:0] FIRMWARE_DATE    = 16'h0000;
    localparam logic        REV_B            = 1'b0;
    localparam logic [15:0] FIRMWARE_VERSION = {VER_MAJOR, VER_MINOR, VER_REV};
    localparam wb_data_t    DATEVERSION      = {REV_B, FIRMWARE_DATE[14:0], FIRMWARE_VERSION};

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////

    localparam int CRATE_SPACE_BIT = 27;
    localparam int IDCTL_ADDR_BITS = 14;

    typedef logic [IDCTL_ADDR_BITS-1:0] idctl_offset_t;

    localparam idctl_offset_t IDCTL_ID_OFFSET      = 'h0;
    localparam idctl_offset_t IDCTL_DATEVER_OFFSET = 'h4;
    localparam idctl_offset_t IDCTL_BTYPE_OFFSET   = 'h8;
    localparam idctl_offset_t IDCTL_BSTAT_OFFSET   = 'hC;

    ////////////////////////////////////////////////////////////
    // Bridge responses and command format
    ////////////////////////////////////////////////////////////

    localparam wb_data_t UNMAPPED_DATA       = 32'hDEAD_BEEF;
    localparam wb_data_t BRIDGE_NONE_DATA    = 32'hFFFF_FFFF;
    localparam wb_data_t BRIDGE_INVALID_DATA = 32'hBAD0_BAD0;
    localparam wb_data_t BRIDGE_TIMEOUT_DATA = 32'hBADD_AA7A;

    localparam int BRIDGE_TIMEOUT_CYCLES = 256;
    localparam int BRIDGE_TIMER_BITS     = $clog2(BRIDGE_TIMEOUT_CYCLES);

    typedef logic [BRIDGE_TIMER_BITS-1:0] bridge_timer_t;

    localparam bridge_timer_t BRIDGE_TIMER_LAST = bridge_timer_t'(BRIDGE_TIMEOUT_CYCLES - 1);

    // Write flag in the address word
    localparam int CMD_WRITE_BIT = 31;

    ////////////////////////////////////////////////////////////
    // Baud tick generators
    ////////////////////////////////////////////////////////////

    // HSK 16x clock, 82/1024 of ps_clk
    localparam int HSK_TICK_ADD  = 82;
    localparam int HSK_TICK_BITS = 10;
    // GPS 16x clock for 38400 baud
    localparam int GPS_TICK_ADD  = 25;
    localparam int GPS_TICK_BITS = 12;

    ////////////////////////////////////////////////////////////
    // Bus structs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    typedef struct packed {
        wb_data_t data;
        link_id_t dest;
        logic     last;
    } crate_cmd_t;

    typedef struct packed {
        wb_data_t data;
        link_id_t link;
    } crate_resp_t;

    typedef enum logic [2:0] {
        IDLE,
        SEND_ADDR,
        SEND_DATA,
        WAIT_RESP,
        DONE
    } bridge_state_t;

endpackage

//--- turf_regs_top.sv
module turf_regs_top (
    input  logic                  ps_clk,
    input  logic                  rst_n_i,
    input  turf_pkg::wb_req_t     wb_req_i,
    output turf_pkg::wb_rsp_t     wb_rsp_o,
    input  turf_pkg::link_mask_t  aurora_up_i,
    output turf_pkg::crate_cmd_t  cmd_o,
    output logic                  cmd_valid_o,
    input  logic                  cmd_ready_i,
    input  turf_pkg::crate_resp_t resp_i,
    input  logic                  resp_valid_i,
    output logic                  resp_ready_o,
    output logic                  hsk_tick_o,
    output logic                  gps_tick_o
);
    import turf_pkg::*;

    wb_req_t                      idctl_req;
    wb_rsp_t                      idctl_rsp;
    wb_req_t                      crate_req;
    wb_rsp_t                      crate_rsp;
    bridge_kind_t [NUM_LINKS-1:0] bridge_type;
    link_mask_t                   bridge_timeout;
    link_mask_t                   bridge_invalid;

    ////////////////////////////////////////////////////////////
    // Register interconnect and slaves
    ////////////////////////////////////////////////////////////

    turf_intercon u_intercon (
        .ps_clk      (ps_clk),
        .rst_n_i     (rst_n_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .idctl_req_o (idctl_req),
        .idctl_rsp_i (idctl_rsp),
        .crate_req_o (crate_req),
        .crate_rsp_i (crate_rsp)
    );

    turf_id_ctrl u_idctrl (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .wb_req_i      (idctl_req),
        .wb_rsp_o      (idctl_rsp),
        .bridge_type_o (bridge_type),
        .timeout_i     (bridge_timeout),
        .invalid_i     (bridge_invalid)
    );

    crate_bridge u_bridge (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .wb_req_i      (crate_req),
        .wb_rsp_o      (crate_rsp),
        .bridge_type_i (bridge_type),
        .aurora_up_i   (aurora_up_i),
        .cmd_o         (cmd_o),
        .cmd_valid_o   (cmd_valid_o),
        .cmd_ready_i   (cmd_ready_i),
        .resp_i        (resp_i),
        .resp_valid_i  (resp_valid_i),
        .resp_ready_o  (resp_ready_o),
        .timeout_o     (bridge_timeout),
        .invalid_o     (bridge_invalid)
    );

    ////////////////////////////////////////////////////////////
    // UART 16x ticks
    ////////////////////////////////////////////////////////////

    baud_tick_gen #(
        .TICK_ADD  (HSK_TICK_ADD),
        .TICK_BITS (HSK_TICK_BITS)
    ) u_hsk_tick (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (hsk_tick_o)
    );

    baud_tick_gen #(
        .TICK_ADD  (GPS_TICK_ADD),
        .TICK_BITS (GPS_TICK_BITS)
    ) u_gps_tick (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (gps_tick_o)
    );

endmodule
